// File: flist.f
hdl/mips_pkg.sv
hdl/fetch_stage.sv
hdl/hazard_unit.sv
hdl/decode_stage.sv
hdl/reg_file.sv
hdl/execute_stage.sv
hdl/memory_writeback_stage.sv
hdl/mips_core.sv
test/mips_core_checker.sv
test/mips_core_assertions.sv
test/tb_mips_core.sv

// File: Makefile
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f flist.f --top-module tb_mips_core \
		-Mdir obj_dir -o sim_mips

run: compile
	./obj_dir/sim_mips | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: test/tb_mips_core.sv
//**************************************************
// testbench for the mips core
// program table as instruction memory, clock, reset
//**************************************************
`timescale 1ns/1ps

module tb_mips_core import mips_pkg::*; ();
    localparam int          PROG_LEN = 30;
    localparam int          CLK_HALF = 4;
    localparam logic [31:0] SEED     = 32'h641b_d547;

    typedef struct packed {
        opcode_t     op;
        funct_t      fn;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;          // r-type destination only
        logic [15:0] imm;
        logic        rand_imm;
        logic [1:0]  stalls;      // stall cycles this one sees in decode
    } step_t;

    // op, funct, rs, rt, rd, imm, random imm, stalls
    step_t steps [PROG_LEN] = '{
        '{OP_ADDI,  6'h00,  5'd0,  5'd1,  5'd0,  16'h0000, 1'b1, 2'd0},
        '{OP_ADDI,  6'h00,  5'd0,  5'd2,  5'd0,  16'h0000, 1'b1, 2'd0},
        '{OP_ADDI,  6'h00,  5'd0,  5'd3,  5'd0,  16'h0000, 1'b1, 2'd0},
        '{OP_ADDI,  6'h00,  5'd0,  5'd4,  5'd0,  16'h0007, 1'b0, 2'd0},
        '{OP_RTYPE, FN_ADD, 5'd1,  5'd2,  5'd5,  16'h0000, 1'b0, 2'd0},
        '{OP_RTYPE, FN_SUB, 5'd3,  5'd4,  5'd6,  16'h0000, 1'b0, 2'd0},
        '{OP_RTYPE, FN_AND, 5'd1,  5'd3,  5'd7,  16'h0000, 1'b0, 2'd0},
        '{OP_RTYPE, FN_OR,  5'd2,  5'd4,  5'd8,  16'h0000, 1'b0, 2'd0},
        '{OP_RTYPE, FN_SLT, 5'd6,  5'd5,  5'd9,  16'h0000, 1'b0, 2'd0},
        '{OP_RTYPE, FN_SLT, 5'd5,  5'd6,  5'd10, 16'h0000, 1'b0, 2'd0},
        '{OP_RTYPE, FN_ADD, 5'd1,  5'd2,  5'd11, 16'h0000, 1'b0, 2'd0},
        '{OP_RTYPE, FN_SUB, 5'd11, 5'd3,  5'd12, 16'h0000, 1'b0, 2'd1},
        '{OP_RTYPE, FN_OR,  5'd12, 5'd11, 5'd13, 16'h0000, 1'b0, 2'd1},
        '{OP_ADDI,  6'h00,  5'd13, 5'd14, 5'd0,  16'h0000, 1'b1, 2'd1},
        '{OP_RTYPE, FN_SLT, 5'd14, 5'd1,  5'd15, 16'h0000, 1'b0, 2'd1},
        '{OP_SW,    6'h00,  5'd0,  5'd14, 5'd0,  16'h0040, 1'b0, 2'd0},
        '{OP_LW,    6'h00,  5'd0,  5'd16, 5'd0,  16'h0040, 1'b0, 2'd0},
        '{OP_RTYPE, FN_ADD, 5'd16, 5'd1,  5'd17, 16'h0000, 1'b0, 2'd2},
        '{OP_LW,    6'h00,  5'd0,  5'd18, 5'd0,  16'h0040, 1'b0, 2'd0},
        '{OP_ADDI,  6'h00,  5'd0,  5'd20, 5'd0,  16'h0000, 1'b1, 2'd0},
        '{OP_RTYPE, FN_ADD, 5'd18, 5'd20, 5'd21, 16'h0000, 1'b0, 2'd1},
        '{OP_BEQ,   6'h00,  5'd1,  5'd1,  5'd0,  16'h0001, 1'b0, 2'd0},
        '{OP_ADDI,  6'h00,  5'd0,  5'd22, 5'd0,  16'h0000, 1'b1, 2'd0},
        '{OP_BNE,   6'h00,  5'd4,  5'd0,  5'd0,  16'h0001, 1'b0, 2'd0},
        '{OP_ADDI,  6'h00,  5'd0,  5'd23, 5'd0,  16'h0000, 1'b1, 2'd0},
        '{OP_BEQ,   6'h00,  5'd4,  5'd0,  5'd0,  16'h0001, 1'b0, 2'd0},
        '{OP_ADDI,  6'h00,  5'd0,  5'd24, 5'd0,  16'h0000, 1'b1, 2'd0},
        '{OP_BNE,   6'h00,  5'd0,  5'd0,  5'd0,  16'h0001, 1'b0, 2'd0},
        '{OP_ADDI,  6'h00,  5'd0,  5'd25, 5'd0,  16'h0000, 1'b1, 2'd0},
        '{OP_BEQ,   6'h00,  5'd0,  5'd0,  5'd0,  16'hffff, 1'b0, 2'd0}   // halt
    };

    logic      SYS_clk;
    logic      SYS_reset;
    word_t     imem_addr;
    word_t     imem_data;
    reg_addr_t dbg_reg_addr;
    word_t     dbg_reg_data;
    word_t     program_mem [PROG_LEN];
    word_t     exp_regs [32];
    word_t     model_mem [256];
    logic [1:0] hold [PROG_LEN];
    logic      done;
    int        error_count;
    int        check_count;

    mips_core i_mips_core (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .dbg_reg_addr (dbg_reg_addr),
        .dbg_reg_data (dbg_reg_data)
    );

    mips_core_checker #(.PROG_LEN(PROG_LEN)) i_checker (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .imem_addr    (imem_addr),
        .dbg_reg_data (dbg_reg_data),
        .hold         (hold),
        .exp_regs     (exp_regs),
        .dbg_reg_addr (dbg_reg_addr),
        .done         (done),
        .error_count  (error_count),
        .check_count  (check_count)
    );

    function automatic word_t encode(step_t s, logic [15:0] imm);
        if (s.op == OP_RTYPE)
            return {s.op, s.rs, s.rt, s.rd, 5'd0, s.fn};
        return {s.op, s.rs, s.rt, imm};
    endfunction

    function automatic word_t fetch_word(word_t addr);
        word_t off;
        int    idx;
        off = addr - RESET_PC;
        idx = int'(off >> 2);
        if ((addr < RESET_PC) || (idx >= PROG_LEN))
            return '0;              // past the end of the program
        return program_mem[idx];
    endfunction

    // builds the program and the expected register image by mips semantics
    initial
    begin
        logic [15:0] imm;
        word_t       a;
        word_t       b;
        word_t       sext;
        word_t       res;
        logic        skip;
        void'($urandom(SEED));
        skip = 1'b0;
        for (int r = 0; r < 32; r++)
            exp_regs[r] = '0;
        for (int m = 0; m < 256; m++)
            model_mem[m] = '0;
        hold[0] = 2'd0;
        for (int i = 0; i < PROG_LEN; i++)
        begin
            imm = steps[i].rand_imm ? 16'($urandom()) : steps[i].imm;
            program_mem[i] = encode(steps[i], imm);
            if (i + 1 < PROG_LEN)
                hold[i + 1] = steps[i].stalls;   // fetch address after a stalled decode
            sext = {{16{imm[15]}}, imm};
            a    = exp_regs[steps[i].rs];
            b    = exp_regs[steps[i].rt];
            if (skip || (i == PROG_LEN - 1))
                skip = 1'b0;                     // killed slot or halt
            else
            begin
                case (steps[i].op)
                    OP_RTYPE:
                    begin
                        case (steps[i].fn)
                            FN_ADD:  res = a + b;
                            FN_SUB:  res = a - b;
                            FN_AND:  res = a & b;
                            FN_OR:   res = a | b;
                            default: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        endcase
                        if (steps[i].rd != '0)
                            exp_regs[steps[i].rd] = res;
                    end
                    OP_ADDI:
                        exp_regs[steps[i].rt] = a + sext;
                    OP_LW:
                        exp_regs[steps[i].rt] = model_mem[(a + sext) >> 2 & 32'hff];
                    OP_SW:
                        model_mem[(a + sext) >> 2 & 32'hff] = b;
                    OP_BEQ:
                        skip = (a == b);
                    OP_BNE:
                        skip = (a != b);
                    default: ;
                endcase
            end
        end
    end

    initial
    begin
        SYS_clk = 1'b0;
        forever #CLK_HALF SYS_clk = ~SYS_clk;
    end

    // instruction memory answers 1 ns after each edge
    initial
    begin
        SYS_reset = 1'b1;
        imem_data = '0;
        repeat (5) @(posedge SYS_clk);
        #1;
        SYS_reset = 1'b0;
        imem_data = fetch_word(imem_addr);
        forever
        begin
            @(posedge SYS_clk);
            #1;
            imem_data = fetch_word(imem_addr);
        end
    end

    initial
    begin
        wait (done);
        $display("checks=%0d errors=%0d", check_count, error_count);
        if (error_count == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    initial
    begin
        repeat (4 * (PROG_LEN + 10)) @(posedge SYS_clk);
        $display("timeout: the halt loop was never reached, checks=%0d errors=%0d",
                 check_count, error_count);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: test/mips_core_assertions.sv
//**************************************************
// pipeline rule assertions
// bound into execute and memory/write-back stages
//**************************************************
`timescale 1ns/1ps

module mips_core_assertions import mips_pkg::*; (
    input logic    SYS_clk,
    input logic    SYS_reset,
    input logic    stall,
    input ex_mem_t ex_out,
    input wb_t     wb,
    input logic    mem_write
);

    // $0 is never a write-back target
    assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        !(wb.reg_write && (wb.addr == '0)))
        else $error("write-back enabled for register 0");

    assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        stall |=> ((ex_out.instr == '0) && (ex_out.ctrl == '0)))
        else $error("no bubble entered execute during a stall");

    assert property (@(posedge SYS_clk)
        $fell(SYS_reset) |-> (!wb.reg_write && !mem_write))
        else $error("write enable high in the first cycle after reset");

endmodule

bind execute_stage mips_core_assertions i_execute_assertions (
    .SYS_clk   (SYS_clk),
    .SYS_reset (SYS_reset),
    .stall     (stall),
    .ex_out    (ex_mem),
    .wb        ('0),
    .mem_write (ex_mem.ctrl.mem_write)
);

bind memory_writeback_stage mips_core_assertions i_memory_assertions (
    .SYS_clk   (SYS_clk),
    .SYS_reset (SYS_reset),
    .stall     (1'b0),
    .ex_out    ('0),
    .wb        (wb),
    .mem_write (ex_mem_q.ctrl.mem_write)
);

// File: test/mips_core_checker.sv
//**************************************************
// mips core checker
// follows the fetch address, then reads back registers
//**************************************************
`timescale 1ns/1ps

module mips_core_checker import mips_pkg::*; #(
    parameter int PROG_LEN = 30
) (
    input  logic       SYS_clk,
    input  logic       SYS_reset,
    input  word_t      imem_addr,
    input  word_t      dbg_reg_data,
    input  logic [1:0] hold [PROG_LEN],
    input  word_t      exp_regs [32],
    output reg_addr_t  dbg_reg_addr,
    output logic       done,
    output int         error_count,
    output int         check_count
);
    word_t halt_addr;

    assign halt_addr = RESET_PC + word_t'(4 * (PROG_LEN - 1));

    initial
    begin
        int    idx;
        int    left;
        int    halt_seen;
        word_t exp_addr;
        dbg_reg_addr = '0;
        done         = 1'b0;
        error_count  = 0;
        check_count  = 0;
        halt_seen    = 0;
        do
            @(negedge SYS_clk);
        while (SYS_reset !== 1'b0);
        idx  = 0;
        left = int'(hold[0]);
        // each address shows once plus its stall cycles
        while (halt_seen == 0)
        begin
            exp_addr = RESET_PC + word_t'(4 * idx);
            check_count++;
            if (imem_addr !== exp_addr)
            begin
                $display("MISMATCH imem_addr expected %h got %h", exp_addr, imem_addr);
                error_count++;
            end
            if (idx == PROG_LEN - 1)
                halt_seen = 1;
            else
            begin
                if (left > 0)
                    left--;
                else
                begin
                    idx++;
                    left = int'(hold[idx]);
                end
                @(negedge SYS_clk);
            end
        end
        while (halt_seen < 3)
        begin
            @(negedge SYS_clk);
            if (imem_addr == halt_addr)
                halt_seen++;
        end
        for (int r = 1; r < 32; r++)
        begin
            @(posedge SYS_clk);
            #1;
            dbg_reg_addr = reg_addr_t'(r);
            @(negedge SYS_clk);
            check_count++;
            if (dbg_reg_data !== exp_regs[r])
            begin
                $display("MISMATCH dbg_reg_data reg %0d expected %h got %h",
                         r, exp_regs[r], dbg_reg_data);
                error_count++;
            end
        end
        done = 1'b1;
    end

endmodule

// File: hdl/mips_core.sv
//**************************************************
// mips core top
// five-stage pipeline with hazard unit and register file
//**************************************************
`timescale 1ns/1ps

module mips_core import mips_pkg::*; (
    input  logic      SYS_clk,
    input  logic      SYS_reset,
    output word_t     imem_addr,
    input  word_t     imem_data,
    input  reg_addr_t dbg_reg_addr,
    output word_t     dbg_reg_data
);
    logic     stall;
    logic     branch_taken;
    word_t    branch_target;
    word_t    dec_instr;
    id_ex_t   id_ex;
    fwd_sel_t fwd_sel;
    word_t    rs_data;
    word_t    rt_data;
    ex_mem_t  ex_mem;
    ex_mem_t  mem_stage;
    wb_t      wb;

    fetch_stage i_fetch_stage (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .pc            (imem_addr)
    );

    decode_stage i_decode_stage (
        .SYS_clk        (SYS_clk),
        .SYS_reset      (SYS_reset),
        .fetch_instr    (imem_data),
        .fetch_pc       (imem_addr),
        .stall          (stall),
        .fwd_sel        (fwd_sel),
        .rs_data        (rs_data),
        .rt_data        (rt_data),
        .mem_alu_result (mem_stage.alu_result),   // memory to decode forward
        .dec_instr      (dec_instr),
        .id_ex          (id_ex),
        .branch_taken   (branch_taken),
        .branch_target  (branch_target)
    );

    reg_file i_reg_file (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .rs_addr   (dec_instr[25:21]),
        .rt_addr   (dec_instr[20:16]),
        .dbg_addr  (dbg_reg_addr),
        .wb        (wb),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .dbg_data  (dbg_reg_data)
    );

    hazard_unit i_hazard_unit (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .dec_instr (dec_instr),
        .ex_dest   (ex_mem.dest),
        .ex_ctrl   (ex_mem.ctrl),
        .mem_dest  (mem_stage.dest),
        .mem_ctrl  (mem_stage.ctrl),
        .stall     (stall),
        .fwd_sel   (fwd_sel)
    );

    execute_stage i_execute_stage (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .stall     (stall),
        .id_ex     (id_ex),
        .ex_mem    (ex_mem)
    );

    memory_writeback_stage i_memory_writeback_stage (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .ex_mem    (ex_mem),
        .mem_stage (mem_stage),
        .wb        (wb)
    );

endmodule

// File: hdl/memory_writeback_stage.sv
//**************************************************
// memory and write-back stages
// ex/mem register, data memory, mem/wb register
//**************************************************
`timescale 1ns/1ps

module memory_writeback_stage import mips_pkg::*; (
    input  logic    SYS_clk,
    input  logic    SYS_reset,
    input  ex_mem_t ex_mem,
    output ex_mem_t mem_stage,
    output wb_t     wb
);
    ex_mem_t            ex_mem_q;
    word_t              dmem [DMEM_WORDS];
    logic [DMEM_AW-1:0] dmem_idx;
    word_t              load_data;
    logic               wb_reg_write_q;
    logic               wb_mem_to_reg_q;
    reg_addr_t          wb_dest_q;
    word_t              wb_load_q;
    word_t              wb_alu_q;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            ex_mem_q <= '0;
        else
            ex_mem_q <= ex_mem;
    end

    assign dmem_idx  = ex_mem_q.alu_result[DMEM_AW+1:2];   // word address
    assign load_data = dmem[dmem_idx];

    always_ff @(posedge SYS_clk)
    begin
        if (ex_mem_q.ctrl.mem_write)
            dmem[dmem_idx] <= ex_mem_q.store_data;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            wb_reg_write_q  <= 1'b0;
            wb_mem_to_reg_q <= 1'b0;
            wb_dest_q       <= '0;
        end
        else
        begin
            wb_reg_write_q  <= ex_mem_q.ctrl.reg_write;
            wb_mem_to_reg_q <= ex_mem_q.ctrl.mem_to_reg;
            wb_dest_q       <= ex_mem_q.dest;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        wb_load_q <= load_data;
        wb_alu_q  <= ex_mem_q.alu_result;
    end

    assign mem_stage = ex_mem_q;
    assign wb        = '{reg_write: wb_reg_write_q, addr: wb_dest_q,
                         data: wb_mem_to_reg_q ? wb_load_q : wb_alu_q};

endmodule

// File: hdl/execute_stage.sv
//**************************************************
// execute stage
// id/ex register, alu control and alu
//**************************************************
`timescale 1ns/1ps

module execute_stage import mips_pkg::*; (
    input  logic    SYS_clk,
    input  logic    SYS_reset,
    input  logic    stall,
    input  id_ex_t  id_ex,
    output ex_mem_t ex_mem
);
    id_ex_t  id_ex_q;
    funct_t  funct;
    alu_op_t alu_op;
    word_t   alu_b;
    word_t   alu_result;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || stall)
            id_ex_q <= '0;              // bubble while decode holds
        else
            id_ex_q <= id_ex;
    end

    assign funct = id_ex_q.instr[5:0];

    always_comb
    begin
        case (id_ex_q.ctrl.alu_class)
            ALU_CLASS_ADD: alu_op = ALU_ADD;
            ALU_CLASS_SUB: alu_op = ALU_SUB;
            ALU_CLASS_FUNCT:
            begin
                case (funct)
                    FN_ADD:  alu_op = ALU_ADD;
                    FN_SUB:  alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: alu_op = ALU_ADD;
                endcase
            end
            default: alu_op = ALU_ADD;
        endcase
    end

    assign alu_b = id_ex_q.ctrl.alu_src ? id_ex_q.imm : id_ex_q.rt_val;

    always_comb
    begin
        case (alu_op)
            ALU_AND: alu_result = id_ex_q.rs_val & alu_b;
            ALU_OR:  alu_result = id_ex_q.rs_val | alu_b;
            ALU_SUB: alu_result = id_ex_q.rs_val - alu_b;
            ALU_SLT: alu_result = ($signed(id_ex_q.rs_val) < $signed(alu_b)) ? 32'd1 : 32'd0;
            ALU_ADD: alu_result = id_ex_q.rs_val + alu_b;
            default: alu_result = id_ex_q.rs_val + alu_b;
        endcase
    end

    assign ex_mem = '{instr: id_ex_q.instr, ctrl: id_ex_q.ctrl, alu_result: alu_result,
                      store_data: id_ex_q.rt_val, dest: id_ex_q.dest};

endmodule

// File: hdl/reg_file.sv
//**************************************************
// register file
// 32 x 32 with write-through and a debug read port
//**************************************************
`timescale 1ns/1ps

module reg_file import mips_pkg::*; (
    input  logic      SYS_clk,
    input  logic      SYS_reset,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  reg_addr_t dbg_addr,
    input  wb_t       wb,
    output word_t     rs_data,
    output word_t     rt_data,
    output word_t     dbg_data
);
    word_t regs [32];                   // entry 0 never written

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wb.reg_write && (wb.addr != '0))
            regs[wb.addr] <= wb.data;
    end

    function automatic word_t read_port(reg_addr_t addr);
        word_t data;
        if (addr == '0)
            data = '0;
        else if (wb.reg_write && (wb.addr == addr))
            data = wb.data;             // write-back visible same cycle
        else
            data = regs[addr];
        return data;
    endfunction

    always_comb
    begin
        rs_data  = read_port(rs_addr);
        rt_data  = read_port(rt_addr);
        dbg_data = read_port(dbg_addr);
    end

endmodule

// File: hdl/decode_stage.sv
//**************************************************
// decode stage
// if/id register, control decode, forwarding and branches
//**************************************************
`timescale 1ns/1ps

module decode_stage import mips_pkg::*; (
    input  logic     SYS_clk,
    input  logic     SYS_reset,
    input  word_t    fetch_instr,
    input  word_t    fetch_pc,
    input  logic     stall,
    input  fwd_sel_t fwd_sel,
    input  word_t    rs_data,
    input  word_t    rt_data,
    input  word_t    mem_alu_result,
    output word_t    dec_instr,
    output id_ex_t   id_ex,
    output logic     branch_taken,
    output word_t    branch_target
);
    word_t     instr_q;
    word_t     pc_q;
    opcode_t   opcode;
    ctrl_t     ctrl;
    word_t     imm;
    word_t     rs_val;
    word_t     rt_val;
    reg_addr_t dest;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            instr_q <= '0;
            pc_q    <= '0;
        end
        else if (!stall)
        begin
            instr_q <= branch_taken ? '0 : fetch_instr;   // kill slot behind taken branch
            pc_q    <= fetch_pc;
        end
    end

    assign opcode = instr_q[31:26];

    always_comb
    begin
        ctrl = '0;
        if (instr_q != '0)              // all-zero word is a bubble
        begin
            case (opcode)
                OP_RTYPE:
                begin
                    ctrl.reg_dst   = 1'b1;
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_class = ALU_CLASS_FUNCT;
                end
                OP_ADDI:
                begin
                    ctrl.alu_src   = 1'b1;
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_class = ALU_CLASS_ADD;
                end
                OP_LW:
                begin
                    ctrl.alu_src    = 1'b1;
                    ctrl.mem_read   = 1'b1;
                    ctrl.mem_to_reg = 1'b1;
                    ctrl.reg_write  = 1'b1;
                    ctrl.alu_class  = ALU_CLASS_ADD;
                end
                OP_SW:
                begin
                    ctrl.alu_src   = 1'b1;
                    ctrl.mem_write = 1'b1;
                    ctrl.alu_class = ALU_CLASS_ADD;
                end
                OP_BEQ, OP_BNE:
                begin
                    ctrl.branch    = 1'b1;
                    ctrl.alu_class = ALU_CLASS_SUB;
                end
                default: ctrl = '0;
            endcase
        end
    end

    assign imm    = {{16{instr_q[15]}}, instr_q[15:0]};
    assign dest   = ctrl.reg_dst ? instr_q[15:11] : instr_q[20:16];
    assign rs_val = fwd_sel[1] ? mem_alu_result : rs_data;
    assign rt_val = fwd_sel[0] ? mem_alu_result : rt_data;

    assign branch_taken  = ctrl.branch &&
                           (((opcode == OP_BEQ) && (rs_val == rt_val)) ||
                            ((opcode == OP_BNE) && (rs_val != rt_val)));
    assign branch_target = pc_q + 32'd4 + {imm[29:0], 2'b00};

    assign dec_instr = instr_q;
    assign id_ex     = '{instr: instr_q, ctrl: ctrl, rs_val: rs_val, rt_val: rt_val,
                         imm: imm, dest: dest};

endmodule

// File: hdl/hazard_unit.sv
//**************************************************
// hazard unit
// stall counter and memory-to-decode forward selects
//**************************************************
`timescale 1ns/1ps

module hazard_unit import mips_pkg::*; (
    input  logic      SYS_clk,
    input  logic      SYS_reset,
    input  word_t     dec_instr,
    input  reg_addr_t ex_dest,
    input  ctrl_t     ex_ctrl,
    input  reg_addr_t mem_dest,
    input  ctrl_t     mem_ctrl,
    output logic      stall,
    output fwd_sel_t  fwd_sel
);
    opcode_t    opcode;
    reg_addr_t  rs;
    reg_addr_t  rt;
    logic       uses_rs;
    logic       uses_rt;
    logic       ex_hit;
    logic       mem_load_hit;
    logic       mem_fwd_ok;
    stall_cnt_t stall_need;
    stall_cnt_t stall_cnt;
    stall_cnt_t stall_cur;

    assign opcode = dec_instr[31:26];
    assign rs     = dec_instr[25:21];
    assign rt     = dec_instr[20:16];

    always_comb
    begin
        uses_rs = 1'b0;
        uses_rt = 1'b0;
        if (dec_instr != '0)
        begin
            case (opcode)
                OP_RTYPE, OP_BEQ, OP_BNE, OP_SW:    // sw reads rt as store data
                begin
                    uses_rs = 1'b1;
                    uses_rt = 1'b1;
                end
                OP_ADDI, OP_LW:
                    uses_rs = 1'b1;
                default: ;
            endcase
        end
    end

    assign ex_hit = ex_ctrl.reg_write && (ex_dest != '0) &&
                    ((uses_rs && (ex_dest == rs)) || (uses_rt && (ex_dest == rt)));

    // load one slot ahead in memory, result only on write-back next cycle
    assign mem_load_hit = mem_ctrl.mem_read && mem_ctrl.reg_write && (mem_dest != '0) &&
                          ((uses_rs && (mem_dest == rs)) || (uses_rt && (mem_dest == rt)));

    always_comb
    begin
        if (ex_hit && ex_ctrl.mem_read)
            stall_need = 2'd2;          // load in execute
        else if (ex_hit || mem_load_hit)
            stall_need = 2'd1;
        else
            stall_need = 2'd0;
    end

    assign stall_cur = (stall_cnt != '0) ? stall_cnt : stall_need;   // no reload mid count
    assign stall     = (stall_cur != '0);

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            stall_cnt <= '0;
        else if (stall)
            stall_cnt <= stall_cur - 2'd1;
    end

    // loads are never forwarded, the stall covers them
    assign mem_fwd_ok = mem_ctrl.reg_write && !mem_ctrl.mem_read && (mem_dest != '0);
    assign fwd_sel    = {mem_fwd_ok && uses_rs && (mem_dest == rs),
                         mem_fwd_ok && uses_rt && (mem_dest == rt)};

endmodule

// File: hdl/fetch_stage.sv
//**************************************************
// fetch stage
// program counter with hold, branch and +4 paths
//**************************************************
`timescale 1ns/1ps

module fetch_stage import mips_pkg::*; (
    input  logic  SYS_clk,
    input  logic  SYS_reset,
    input  logic  stall,
    input  logic  branch_taken,
    input  word_t branch_target,
    output word_t pc
);

    // stall wins over branch, a stalled branch may see stale operands
    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            pc <= RESET_PC;
        else if (stall)
            pc <= pc;                   // hold while hazard pending
        else if (branch_taken)
            pc <= branch_target;        // resolved in decode
        else
            pc <= pc + 32'd4;
    end

endmodule

// File: hdl/mips_pkg.sv
//**************************************************
// mips pipeline package
// shared widths, encodings and pipeline register types
//**************************************************
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [1:0]  fwd_sel_t;     // [1] rs, [0] rt
    typedef logic [1:0]  stall_cnt_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  alu_class_t;

    localparam word_t RESET_PC   = 32'h0040_0000;
    localparam int    DMEM_WORDS = 256;
    localparam int    DMEM_AW    = $clog2(DMEM_WORDS);

    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;

    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_AND = 6'h24;
    localparam funct_t FN_OR  = 6'h25;
    localparam funct_t FN_SLT = 6'h2a;

    localparam alu_op_t ALU_AND = 4'h0;
    localparam alu_op_t ALU_OR  = 4'h1;
    localparam alu_op_t ALU_ADD = 4'h2;
    localparam alu_op_t ALU_SUB = 4'h6;
    localparam alu_op_t ALU_SLT = 4'h7;

    localparam alu_class_t ALU_CLASS_ADD   = 2'b00;   // address and addi
    localparam alu_class_t ALU_CLASS_SUB   = 2'b01;   // branch compare
    localparam alu_class_t ALU_CLASS_FUNCT = 2'b10;   // r-type, from funct

    typedef struct packed {
        logic       reg_dst;      // rd when set, else rt
        logic       alu_src;      // immediate operand
        logic       mem_read;
        logic       mem_write;
        logic       mem_to_reg;
        logic       reg_write;
        logic       branch;
        alu_class_t alu_class;
    } ctrl_t;

    typedef struct packed {
        word_t     instr;
        ctrl_t     ctrl;
        word_t     rs_val;
        word_t     rt_val;
        word_t     imm;
        reg_addr_t dest;
    } id_ex_t;

    typedef struct packed {
        word_t     instr;
        ctrl_t     ctrl;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t dest;
    } ex_mem_t;

    typedef struct packed {
        logic      reg_write;
        reg_addr_t addr;
        word_t     data;
    } wb_t;

endpackage
